// File: source/cache_macros.svh
// data cache sizing constants for geometry, word/line widths and address split

`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// --------------------
// cache geometry
// --------------------
`define CACHE_SETS      4     // sets per way
`define CACHE_WAYS      2     // two-way set associative

// --------------------
// data widths
// --------------------
`define WORD_BITS       32    // processor data word
`define LINE_WORDS      4     // words per cache line
`define LINE_BITS       128   // one full memory line

// word address is [29:0], tag sits on top of set and word index
`define PROC_ADDR_BITS  30
`define TAG_BITS        26    // address bits 29..4

`endif

// File: source/cache_pkg.sv
// data cache package with address field, word and line types and the controller states

`include "cache_macros.svh"

package cache_pkg;

	// --------------------
	// address fields
	// --------------------
	typedef logic [`PROC_ADDR_BITS-1:0] word_addr_t;     // processor word address
	typedef logic [`TAG_BITS-1:0] tag_t;                 // upper bits kept per line
	typedef logic [$clog2(`CACHE_SETS)-1:0] set_idx_t;   // word address bits 3..2
	typedef logic [$clog2(`LINE_WORDS)-1:0] word_idx_t;  // word address bits 1..0

	// line address drops the word index
	typedef logic [`PROC_ADDR_BITS-$clog2(`LINE_WORDS)-1:0] line_addr_t;

	// --------------------
	// data
	// --------------------
	typedef logic [`WORD_BITS-1:0] word_t;
	typedef logic [`LINE_BITS-1:0] line_t;

	// compare/allocate controller
	typedef enum logic [1:0] {
		ST_IDLE,      // one cycle out of reset
		ST_COMPARE,   // tag check and hit service
		ST_ALLOCATE   // waiting on the memory line
	} ctrl_state_t;

endpackage

// File: source/cache_way.sv
// cache way holding valid, tag and line per set, with tag compare and word/line update
`timescale 1ns/100ps

`include "cache_macros.svh"

module cache_way (
	input  logic                  clk,
	input  logic                  proc_reset,
	input  cache_pkg::set_idx_t   set_idx,
	input  cache_pkg::tag_t       tag,
	input  cache_pkg::word_idx_t  word_idx,
	input  logic                  fill,
	input  cache_pkg::line_t      fill_line,
	input  logic                  word_write,
	input  cache_pkg::word_t      wdata,
	output logic                  hit,
	output cache_pkg::word_t      rdata
);

	import cache_pkg::*;

	// --------------------
	// storage
	// --------------------
	logic [`CACHE_SETS-1:0] valid;           // one per set
	tag_t                   tag_mem  [`CACHE_SETS];
	line_t                  line_mem [`CACHE_SETS];

	line_t cur_line;   // line of the addressed set
	tag_t  cur_tag;

	// --------------------
	// lookup
	// --------------------
	assign cur_line = line_mem[set_idx];
	assign cur_tag  = tag_mem[set_idx];

	// hit needs a filled entry with the same upper address bits
	assign hit = valid[set_idx] && (cur_tag == tag);

	// word select happens regardless of hit, the controller decides use
	assign rdata = cur_line[word_idx*`WORD_BITS +: `WORD_BITS];

	// --------------------
	// valid bits
	// --------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			valid <= '0;   // cold cache
		end else if (fill) begin
			valid[set_idx] <= 1'b1;
		end
	end

	// --------------------
	// tag and data update
	// --------------------
	always_ff @(posedge clk) begin
		if (fill) begin
			line_mem[set_idx] <= fill_line;   // whole line from memory
			tag_mem[set_idx]  <= tag;
		end else if (word_write) begin
			// write hit, only the addressed word changes
			line_mem[set_idx][word_idx*`WORD_BITS +: `WORD_BITS] <= wdata;
		end
	end

endmodule

// File: source/cache_ctrl.sv
// cache controller running the compare/allocate FSM and the per-set replacement bits
`timescale 1ns/100ps

`include "cache_macros.svh"

module cache_ctrl (
	input  logic                 clk,
	input  logic                 proc_reset,
	input  logic                 proc_read,
	input  logic                 proc_write,
	input  cache_pkg::set_idx_t  set_idx,
	input  logic                 hit0,
	input  logic                 hit1,
	input  logic                 mem_ready,
	output logic                 proc_stall,
	output logic                 mem_read,
	output logic                 fill0,
	output logic                 fill1,
	output logic                 write0,
	output logic                 write1,
	output logic                 rd_sel
);

	import cache_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_nxt;

	// way to refill next, per set
	logic [`CACHE_SETS-1:0] repl;

	logic any_hit;
	logic read_miss;

	assign any_hit   = hit0 | hit1;
	assign read_miss = proc_read & ~any_hit;

	// way 0 wins when both hit
	assign rd_sel = ~hit0;

	// --------------------
	// next state
	// --------------------
	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				state_nxt = ST_COMPARE;
			end
			ST_COMPARE: begin
				if (read_miss) begin
					state_nxt = ST_ALLOCATE;
				end
			end
			ST_ALLOCATE: begin
				if (mem_ready) begin
					state_nxt = ST_COMPARE;   // line lands at this edge
				end
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	// --------------------
	// outputs
	// --------------------
	always_comb begin
		proc_stall = 1'b0;
		mem_read   = 1'b0;
		fill0      = 1'b0;
		fill1      = 1'b0;
		write0     = 1'b0;
		write1     = 1'b0;
		case (state)
			ST_IDLE: begin
				proc_stall = 1'b1;   // hold the first request back
			end
			ST_COMPARE: begin
				proc_stall = read_miss;
				// a write that misses both ways is dropped
				if (proc_write) begin
					write0 = hit0;
					write1 = hit1 & ~hit0;
				end
			end
			ST_ALLOCATE: begin
				proc_stall = 1'b1;
				mem_read   = ~mem_ready;
				fill0      = mem_ready & ~repl[set_idx];
				fill1      = mem_ready & repl[set_idx];
			end
			default: begin
				proc_stall = 1'b1;
			end
		endcase
	end

	// --------------------
	// state and replacement
	// --------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= ST_IDLE;
			repl  <= '0;
		end else begin
			state <= state_nxt;
			// alternate only on refill, hits leave it alone
			if (fill0 || fill1) begin
				repl[set_idx] <= ~repl[set_idx];
			end
		end
	end

endmodule

// File: source/dcache_top.sv
// data cache top level joining two ways and the controller to the processor and memory ports
`timescale 1ns/100ps

`include "cache_macros.svh"

module dcache_top (
	input  logic                   clk,
	input  logic                   proc_reset,
	input  logic                   proc_read,
	input  logic                   proc_write,
	input  cache_pkg::word_addr_t  proc_addr,
	input  cache_pkg::word_t       proc_wdata,
	output cache_pkg::word_t       proc_rdata,
	output logic                   proc_stall,
	output logic                   mem_read,
	output cache_pkg::line_addr_t  mem_addr,
	input  cache_pkg::line_t       mem_rdata,
	input  logic                   mem_ready
);

	import cache_pkg::*;

	tag_t      addr_tag;
	set_idx_t  addr_set;
	word_idx_t addr_word;

	logic [`CACHE_WAYS-1:0] hit;
	logic [`CACHE_WAYS-1:0] fill;
	logic [`CACHE_WAYS-1:0] word_write;
	word_t                  way_rdata [`CACHE_WAYS];
	logic                   rd_sel;

	// --------------------
	// address split
	// --------------------
	assign addr_tag  = proc_addr[`PROC_ADDR_BITS-1 -: `TAG_BITS];
	assign addr_set  = proc_addr[$bits(word_idx_t) +: $bits(set_idx_t)];
	assign addr_word = proc_addr[$bits(word_idx_t)-1:0];
	assign mem_addr  = proc_addr[`PROC_ADDR_BITS-1:$bits(word_idx_t)];   // line bits

	// zero unless a read hit is served this cycle
	assign proc_rdata = (proc_read && !proc_stall) ? way_rdata[rd_sel] : '0;

	// --------------------
	// ways and controller
	// --------------------
	cache_way way0 (
		.clk(clk), .proc_reset(proc_reset), .set_idx(addr_set), .tag(addr_tag),
		.word_idx(addr_word), .fill(fill[0]), .fill_line(mem_rdata),
		.word_write(word_write[0]), .wdata(proc_wdata), .hit(hit[0]), .rdata(way_rdata[0])
	);

	cache_way way1 (
		.clk(clk), .proc_reset(proc_reset), .set_idx(addr_set), .tag(addr_tag),
		.word_idx(addr_word), .fill(fill[1]), .fill_line(mem_rdata),
		.word_write(word_write[1]), .wdata(proc_wdata), .hit(hit[1]), .rdata(way_rdata[1])
	);

	cache_ctrl ctrl (
		.clk(clk), .proc_reset(proc_reset), .proc_read(proc_read),
		.proc_write(proc_write), .set_idx(addr_set), .hit0(hit[0]), .hit1(hit[1]),
		.mem_ready(mem_ready), .proc_stall(proc_stall), .mem_read(mem_read),
		.fill0(fill[0]), .fill1(fill[1]), .write0(word_write[0]), .write1(word_write[1]),
		.rd_sel(rd_sel)
	);

endmodule

// File: verif/dcache_assert.sv
// data cache assertion checker for memory port and refill rules, bound into the top level
`timescale 1ns/100ps

`include "cache_macros.svh"

module dcache_assert (
	input logic                   clk,
	input logic                   proc_reset,
	input logic                   proc_stall,
	input logic                   mem_read,
	input logic                   mem_ready,
	input cache_pkg::line_addr_t  mem_addr,
	input logic [`CACHE_WAYS-1:0] fill
);

	import cache_pkg::*;

	int unsigned assert_errs = 0;   // read by the testbench at the end

	// a line request always holds the processor
	a_read_stalls: assert property (@(posedge clk) disable iff (proc_reset)
		mem_read |-> proc_stall)
	else begin
		$error("mem_read high while proc_stall is low");
		assert_errs++;
	end

	a_addr_stable: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_read && !mem_ready) ##1 mem_read |-> $stable(mem_addr))
	else begin
		$error("mem_addr changed during a pending line request");
		assert_errs++;
	end

	a_one_fill: assert property (@(posedge clk) disable iff (proc_reset)
		!(fill[0] && fill[1]))
	else begin
		$error("both ways filled in the same cycle");
		assert_errs++;
	end

	// idle cycle right after reset
	a_reset_quiet: assert property (@(posedge clk) $fell(proc_reset) |-> !mem_read)
	else begin
		$error("mem_read high in the cycle after reset");
		assert_errs++;
	end

endmodule

// File: verif/dcache_tb.sv
// data cache testbench with random requests, a line memory model and a shadow cache model
`timescale 1ns/100ps

`include "cache_macros.svh"

module dcache_tb;

	import cache_pkg::*;

	localparam int NUM_RAND   = 400;
	localparam int NUM_DIR    = 11;
	localparam int NUM_REQ    = NUM_RAND + NUM_DIR;
	localparam int MAX_CYCLES = 12 * NUM_REQ;
	localparam logic [31:0] WORD_STEP = 32'h9e37_79b1;   // odd step between words of a line
	localparam int KIND_READ  = 0;
	localparam int KIND_WRITE = 1;

	logic       clk;
	logic       proc_reset;
	logic       proc_read;
	logic       proc_write;
	word_addr_t proc_addr;
	word_t      proc_wdata;
	word_t      proc_rdata;
	logic       proc_stall;
	logic       mem_read;
	line_addr_t mem_addr;
	line_t      mem_rdata;
	logic       mem_ready;

	integer seed;
	int     cycles = 0;
	int     word_errs = 0;
	int     addr_errs = 0;
	int     flag_errs = 0;

	// --------------------
	// shadow cache
	// --------------------
	logic  m_valid [`CACHE_WAYS][`CACHE_SETS];
	tag_t  m_tag   [`CACHE_WAYS][`CACHE_SETS];
	word_t m_data  [`CACHE_WAYS][`CACHE_SETS][`LINE_WORDS];
	logic  m_repl  [`CACHE_SETS];   // next way to refill

	dcache_top DUT (
		.clk(clk), .proc_reset(proc_reset), .proc_read(proc_read), .proc_write(proc_write),
		.proc_addr(proc_addr), .proc_wdata(proc_wdata), .proc_rdata(proc_rdata),
		.proc_stall(proc_stall), .mem_read(mem_read), .mem_addr(mem_addr),
		.mem_rdata(mem_rdata), .mem_ready(mem_ready)
	);

	bind dcache_top dcache_assert u_chk (
		.clk(clk), .proc_reset(proc_reset), .proc_stall(proc_stall), .mem_read(mem_read),
		.mem_ready(mem_ready), .mem_addr(mem_addr), .fill(fill)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > MAX_CYCLES) begin
			$display("timeout after %0d cycles, a request never completed", cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// --------------------
	// compare tasks
	// --------------------
	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("FAILED %s expected %h got %h", name, exp, act);
			word_errs++;
		end
	endtask

	task automatic check_line_addr(input string name, input line_addr_t exp, input line_addr_t act);
		if (act !== exp) begin
			$display("FAILED %s expected %h got %h", name, exp, act);
			addr_errs++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED %s expected %h got %h", name, exp, act);
			flag_errs++;
		end
	endtask

	// --------------------
	// memory model
	// --------------------
	function automatic word_t mem_word(input line_addr_t line, input int k);
		return word_t'(line) + k * WORD_STEP;
	endfunction

	function automatic line_t mem_line(input line_addr_t line);
		line_t l;
		for (int k = 0; k < `LINE_WORDS; k++) begin
			l[k*`WORD_BITS +: `WORD_BITS] = mem_word(line, k);
		end
		return l;
	endfunction

	// waits for the line request, then answers after 1 to 4 cycles
	task automatic serve_memory(input line_addr_t exp_addr);
		int delay;
		@(negedge clk);
		while (!mem_read) @(negedge clk);
		check_line_addr("mem_addr", exp_addr, mem_addr);
		delay = 1 + $unsigned($random(seed)) % 4;
		for (int i = 1; i < delay; i++) begin
			@(negedge clk);
			check_flag("mem_read", 1'b1, mem_read);
			check_line_addr("mem_addr", exp_addr, mem_addr);
		end
		@(posedge clk);
		#1;
		mem_ready = 1'b1;
		mem_rdata = mem_line(exp_addr);
		@(posedge clk);
		#1;
		mem_ready = 1'b0;
		mem_rdata = '0;
	endtask

	// --------------------
	// shadow model rules
	// --------------------
	function automatic int find_way(input word_addr_t a);
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (m_valid[w][a[3:2]] && m_tag[w][a[3:2]] == a[29:4]) return w;
		end
		return -1;
	endfunction

	task automatic model_fill(input word_addr_t a);
		set_idx_t s;
		int       w;
		s = a[3:2];
		w = m_repl[s];
		m_valid[w][s] = 1'b1;
		m_tag[w][s] = a[29:4];
		for (int k = 0; k < `LINE_WORDS; k++) begin
			m_data[w][s][k] = mem_word(a[29:2], k);
		end
		m_repl[s] = ~m_repl[s];   // alternate on every refill
	endtask

	function automatic word_addr_t make_addr(input int t, input int s, input int k);
		tag_t tg;
		case (t)
			0:       tg = 26'h1234567;
			1:       tg = 26'h0abcdef;
			default: tg = 26'h3000042;
		endcase
		return {tg, set_idx_t'(s), word_idx_t'(k)};
	endfunction

	// one request, entered and left 1 ns after a rising edge
	task automatic do_request(input int kind, input word_addr_t a, input word_t wd);
		int w;
		w = find_way(a);
		proc_read = (kind == KIND_READ);
		proc_write = (kind == KIND_WRITE);
		proc_addr = a;
		proc_wdata = wd;
		@(negedge clk);
		check_flag("mem_read", 1'b0, mem_read);
		if (kind == KIND_READ && w < 0) begin
			check_flag("proc_stall", 1'b1, proc_stall);   // read miss
			serve_memory(a[29:2]);
			model_fill(a);
			w = find_way(a);
			@(negedge clk);
			while (proc_stall) @(negedge clk);
		end else begin
			check_flag("proc_stall", 1'b0, proc_stall);
		end
		if (kind == KIND_READ) begin
			check_word("proc_rdata", m_data[w][a[3:2]][a[1:0]], proc_rdata);
		end else begin
			check_word("proc_rdata", '0, proc_rdata);
		end
		if (kind == KIND_WRITE && w >= 0) begin
			m_data[w][a[3:2]][a[1:0]] = wd;   // write miss leaves the model alone
		end
		@(posedge clk);
		#1;
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		int kind;
		clk = 1'b0;
		proc_reset = 1'b1;
		proc_read = 1'b0;
		proc_write = 1'b0;
		proc_addr = '0;
		proc_wdata = '0;
		mem_rdata = '0;
		mem_ready = 1'b0;
		seed = 32'hd072;
		for (int s = 0; s < `CACHE_SETS; s++) begin
			m_repl[s] = 1'b0;
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				m_valid[w][s] = 1'b0;
			end
		end
		repeat (2) @(posedge clk);
		#1;
		proc_reset = 1'b0;
		@(negedge clk);
		check_flag("proc_stall", 1'b1, proc_stall);   // idle cycle out of reset
		check_flag("mem_read", 1'b0, mem_read);
		@(posedge clk);
		#1;

		// cold read, hit, write hit, write miss and eviction in set 1
		do_request(KIND_READ, make_addr(0, 1, 0), '0);
		do_request(KIND_READ, make_addr(0, 1, 0), '0);
		do_request(KIND_WRITE, make_addr(0, 1, 2), 32'hcafe_0001);
		do_request(KIND_READ, make_addr(0, 1, 2), '0);
		do_request(KIND_READ, make_addr(0, 1, 1), '0);
		do_request(KIND_WRITE, make_addr(1, 1, 0), 32'h5555_aaaa);
		do_request(KIND_READ, make_addr(1, 1, 0), '0);
		do_request(KIND_READ, make_addr(2, 1, 3), '0);
		do_request(KIND_READ, make_addr(1, 1, 1), '0);   // later-filled way survives
		do_request(KIND_READ, make_addr(0, 1, 2), '0);   // evicted, write is lost
		do_request(KIND_READ, make_addr(1, 1, 0), '0);

		for (int i = 0; i < NUM_RAND; i++) begin
			kind = $unsigned($random(seed)) % 3;
			do_request(kind, make_addr($unsigned($random(seed)) % 3,
				$unsigned($random(seed)) % 4, $unsigned($random(seed)) % 4), $random(seed));
		end

		$display("errors: word %0d, line address %0d, flag %0d, assertion %0d",
			word_errs, addr_errs, flag_errs, DUT.u_chk.assert_errs);
		if (word_errs + addr_errs + flag_errs + DUT.u_chk.assert_errs == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: sources.f
+incdir+source
source/cache_pkg.sv
source/cache_way.sv
source/cache_ctrl.sv
source/dcache_top.sv
verif/dcache_assert.sv
verif/dcache_tb.sv
